/* verilog/rv_pipe_params.svh */
`ifndef RV_PIPE_PARAMS_SVH
`define RV_PIPE_PARAMS_SVH

// data path and address width
`define RV_XLEN 32

// architectural register count
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* verilog/rv_pipe_pkg.sv */
`default_nettype none

`include "rv_pipe_params.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

    // zero values of all enums form a no-op
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS
    } alu_op_t;

    typedef enum logic [2:0] {BR_NONE, BR_JAL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE} br_op_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;
    typedef enum logic [1:0] {MEM_NONE, MEM_LW, MEM_SW} mem_op_t;

    typedef struct packed {
        alu_op_t   alu_op;
        br_op_t    br_op;
        wb_sel_t   wb_sel;
        mem_op_t   mem_op;
        logic      rf_wen;
        reg_addr_t wb_addr;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     imm;
        logic      use_imm;
        logic      is_ecall;
    } ctrl_t;

    // one writer as seen from operand select
    typedef struct packed {
        logic      valid;
        logic      can_forward;
        reg_addr_t addr;
        word_t     wdata;
    } fw_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } id_payload_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
    } ds_payload_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t op1;
        word_t op2;
        word_t store_data;
    } exe_payload_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t alu_out;
        word_t store_data;
    } mem_payload_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t alu_out;
        word_t mem_rdata;
    } wb_payload_t;

endpackage

`default_nettype wire

/* verilog/stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     flush,
    input  wire logic     in_valid,
    input  wire payload_t in_payload,
    output logic          out_valid,
    output payload_t      out_payload
);

    // flush wins over stall so a held slot can still be killed
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage import rv_pipe_pkg::*; (
    input  wire logic        id_valid,
    input  wire id_payload_t id_payload,
    output logic             ds_valid_out,
    output ds_payload_t      ds_payload_out
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam word_t      ECALL     = 32'h0000_0073;

    word_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    alu_fn;
    ctrl_t      ctrl;

    assign inst     = id_payload.inst;
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // shared by register and immediate forms, sub only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode == OP_REG && funct7_5) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = funct7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        // unknown encodings stay all zero
        ctrl         = '0;
        ctrl.wb_addr = inst[11:7];
        case (opcode)
            OP_REG: begin
                ctrl.rs1_addr = inst[19:15];
                ctrl.rs2_addr = inst[24:20];
                ctrl.alu_op   = alu_fn;
                ctrl.rf_wen   = 1'b1;
            end
            OP_IMM: begin
                ctrl.rs1_addr = inst[19:15];
                ctrl.alu_op   = alu_fn;
                ctrl.imm      = imm_i;
                ctrl.use_imm  = 1'b1;
                ctrl.rf_wen   = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op  = ALU_PASS;
                ctrl.imm     = imm_u;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
            end
            OP_JAL: begin
                ctrl.br_op  = BR_JAL;
                ctrl.wb_sel = WB_PC4;
                ctrl.imm    = imm_j;
                ctrl.rf_wen = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.rs1_addr = inst[19:15];
                ctrl.rs2_addr = inst[24:20];
                ctrl.imm      = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_op = BR_BEQ;
                    3'b001:  ctrl.br_op = BR_BNE;
                    3'b100:  ctrl.br_op = BR_BLT;
                    3'b101:  ctrl.br_op = BR_BGE;
                    default: ctrl.br_op = BR_NONE;
                endcase
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.rs1_addr = inst[19:15];
                    ctrl.imm      = imm_i;
                    ctrl.use_imm  = 1'b1;
                    ctrl.mem_op   = MEM_LW;
                    ctrl.wb_sel   = WB_MEM;
                    ctrl.rf_wen   = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.rs1_addr = inst[19:15];
                    ctrl.rs2_addr = inst[24:20];
                    ctrl.imm      = imm_s;
                    ctrl.use_imm  = 1'b1;
                    ctrl.mem_op   = MEM_SW;
                end
            end
            default: begin
                ctrl.is_ecall = (inst == ECALL);
            end
        endcase
    end

    assign ds_valid_out        = id_valid;
    assign ds_payload_out.pc   = id_payload.pc;
    assign ds_payload_out.ctrl = ctrl;

endmodule

`default_nettype wire

/* verilog/operand_select.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_select import rv_pipe_pkg::*; (
    input  wire logic        ds_valid,
    input  wire ds_payload_t ds_payload,
    input  wire word_t       rf_rdata1,
    input  wire word_t       rf_rdata2,
    output reg_addr_t        rf_raddr1,
    output reg_addr_t        rf_raddr2,
    input  wire fw_t         exe_fw,
    input  wire fw_t         mem_fw,
    input  wire fw_t         wb_fw,
    output logic             hazard_stall,
    output exe_payload_t     exe_payload_out
);

    ctrl_t ctrl;
    word_t src1;
    word_t src2;
    logic  stall1;
    logic  stall2;

    // x0 never matches
    function automatic logic hits(input fw_t fw, input reg_addr_t addr);
        return fw.valid && addr != '0 && fw.addr == addr;
    endfunction

    // youngest writer first, top bit asks for a stall
    function automatic logic [$bits(word_t):0] resolve(
        input reg_addr_t addr,
        input word_t     rf_data,
        input fw_t       exe_e,
        input fw_t       mem_e,
        input fw_t       wb_e
    );
        if (hits(exe_e, addr)) begin
            return {!exe_e.can_forward, exe_e.wdata};
        end else if (hits(mem_e, addr)) begin
            return {!mem_e.can_forward, mem_e.wdata};
        end else if (hits(wb_e, addr)) begin
            return {!wb_e.can_forward, wb_e.wdata};
        end
        return {1'b0, rf_data};
    endfunction

    assign ctrl      = ds_payload.ctrl;
    assign rf_raddr1 = ctrl.rs1_addr;
    assign rf_raddr2 = ctrl.rs2_addr;

    assign {stall1, src1} = resolve(ctrl.rs1_addr, rf_rdata1, exe_fw, mem_fw, wb_fw);
    assign {stall2, src2} = resolve(ctrl.rs2_addr, rf_rdata2, exe_fw, mem_fw, wb_fw);

    assign hazard_stall = ds_valid && (stall1 || stall2);

    always_comb begin
        exe_payload_out.pc         = ds_payload.pc;
        exe_payload_out.ctrl       = ctrl;
        exe_payload_out.op1        = src1;
        exe_payload_out.op2        = ctrl.use_imm ? ctrl.imm : src2;
        // rs2 kept apart for stores
        exe_payload_out.store_data = src2;
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rv_pipe_pkg::*; (
    input  wire logic         exe_valid,
    input  wire exe_payload_t exe_payload,
    output logic              branch_taken,
    output word_t             branch_target,
    output mem_payload_t      mem_payload_out
);

    ctrl_t      ctrl;
    word_t      op1;
    word_t      op2;
    word_t      alu_out;
    logic [4:0] shamt;
    logic       cond;

    assign ctrl  = exe_payload.ctrl;
    assign op1   = exe_payload.op1;
    assign op2   = exe_payload.op2;
    assign shamt = op2[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  alu_out = op1 - op2;
            ALU_AND:  alu_out = op1 & op2;
            ALU_OR:   alu_out = op1 | op2;
            ALU_XOR:  alu_out = op1 ^ op2;
            ALU_SLT:  alu_out = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_out = word_t'(op1 < op2);
            ALU_SLL:  alu_out = op1 << shamt;
            ALU_SRL:  alu_out = op1 >> shamt;
            ALU_SRA:  alu_out = $signed(op1) >>> shamt;
            // lui
            ALU_PASS: alu_out = op2;
            default:  alu_out = op1 + op2;
        endcase
    end

    // branches read rs2 through op2
    always_comb begin
        case (ctrl.br_op)
            BR_JAL:  cond = 1'b1;
            BR_BEQ:  cond = (op1 == op2);
            BR_BNE:  cond = (op1 != op2);
            BR_BLT:  cond = ($signed(op1) < $signed(op2));
            BR_BGE:  cond = ($signed(op1) >= $signed(op2));
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken  = exe_valid && cond;
    assign branch_target = exe_payload.pc + ctrl.imm;

    always_comb begin
        mem_payload_out.pc         = exe_payload.pc;
        mem_payload_out.ctrl       = ctrl;
        mem_payload_out.alu_out    = alu_out;
        mem_payload_out.store_data = exe_payload.store_data;
    end

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_stage import rv_pipe_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         mem_valid,
    input  wire mem_payload_t mem_payload,
    output logic              dmem_req,
    output logic              dmem_we,
    output word_t             dmem_addr,
    output word_t             dmem_wdata,
    input  wire logic         dmem_ready,
    input  wire word_t        dmem_rdata,
    output logic              mem_stall,
    output wb_payload_t       wb_payload_out
);

    logic active;
    logic req_q;
    logic done;

    assign active = mem_valid && mem_payload.ctrl.mem_op != MEM_NONE;
    assign done   = req_q && dmem_ready;

    // request comes from a flop, raised the cycle after the access enters
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= active && !done;
        end
    end

    assign dmem_req   = req_q;
    assign dmem_we    = req_q && mem_payload.ctrl.mem_op == MEM_SW;
    assign dmem_addr  = mem_payload.alu_out;
    assign dmem_wdata = mem_payload.store_data;
    assign mem_stall  = active && !done;

    // read data is only sampled in the completing cycle
    always_comb begin
        wb_payload_out.pc        = mem_payload.pc;
        wb_payload_out.ctrl      = mem_payload.ctrl;
        wb_payload_out.alu_out   = mem_payload.alu_out;
        wb_payload_out.mem_rdata = dmem_rdata;
    end

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_params.svh"

module result_stage import rv_pipe_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_valid,
    input  wire wb_payload_t wb_payload,
    input  wire reg_addr_t   rf_raddr1,
    input  wire reg_addr_t   rf_raddr2,
    output word_t            rf_rdata1,
    output word_t            rf_rdata2,
    output word_t            wb_wdata,
    output word_t            gp,
    output logic             exit
);

    word_t regs [`RV_NUM_REGS];
    ctrl_t ctrl;

    assign ctrl = wb_payload.ctrl;

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_wdata = wb_payload.mem_rdata;
            WB_PC4:  wb_wdata = wb_payload.pc + word_t'(4);
            default: wb_wdata = wb_payload.alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_valid && ctrl.rf_wen && ctrl.wb_addr != '0) begin
            regs[ctrl.wb_addr] <= wb_wdata;
        end
    end

    // x0 is never written, so reads of it are tied off
    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];
    assign gp        = regs[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            exit <= 1'b0;
        end else if (wb_valid && ctrl.is_ecall) begin
            exit <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_params.svh"

module rv_core import rv_pipe_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    output word_t      fetch_addr,
    input  wire word_t fetch_inst,
    output logic       dmem_req,
    output logic       dmem_we,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    input  wire logic  dmem_ready,
    input  wire word_t dmem_rdata,
    output word_t      gp,
    output logic       exit
);

    word_t        pc;
    word_t        target_q;
    word_t        branch_target;
    word_t        rf_rdata1;
    word_t        rf_rdata2;
    word_t        wb_wdata;
    reg_addr_t    rf_raddr1;
    reg_addr_t    rf_raddr2;
    logic         branch_taken;
    logic         branch_redirect;
    logic         redirect_q;
    logic         front_flush;
    logic         id_stall;
    logic         ds_stall;
    logic         exe_stall;
    logic         mem_stall;
    logic         hazard_stall;
    logic         id_valid;
    logic         dec_valid;
    logic         ds_valid;
    logic         exe_valid;
    logic         mem_valid;
    logic         wb_valid;
    id_payload_t  fetch_payload;
    id_payload_t  id_payload;
    ds_payload_t  dec_payload;
    ds_payload_t  ds_payload;
    exe_payload_t sel_payload;
    exe_payload_t exe_payload;
    mem_payload_t alu_payload;
    mem_payload_t mem_payload;
    wb_payload_t  dmem_payload;
    wb_payload_t  wb_payload;
    fw_t          exe_fw;
    fw_t          mem_fw;
    fw_t          wb_fw;

    // stall chain, everything above mem holds on back-pressure
    assign exe_stall = mem_stall;
    assign ds_stall  = exe_stall || hazard_stall;
    assign id_stall  = ds_stall;

    // a branch only redirects once it is free to leave execute
    assign branch_redirect = branch_taken && !exe_stall;
    assign front_flush     = branch_redirect || redirect_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= branch_redirect;
        end
    end

    always_ff @(posedge clk) begin
        target_q <= branch_target;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (redirect_q) begin
            pc <= target_q;
        end else if (!id_stall) begin
            pc <= pc + word_t'(4);
        end
    end

    assign fetch_addr    = pc;
    assign fetch_payload = '{pc: pc, inst: fetch_inst};

    // execute can never forward, so any match there stalls decode
    assign exe_fw = '{
        valid:       exe_valid && exe_payload.ctrl.rf_wen,
        can_forward: 1'b0,
        addr:        exe_payload.ctrl.wb_addr,
        wdata:       '0
    };

    // load data is not there yet in mem
    assign mem_fw = '{
        valid:       mem_valid && mem_payload.ctrl.rf_wen,
        can_forward: mem_payload.ctrl.mem_op != MEM_LW,
        addr:        mem_payload.ctrl.wb_addr,
        wdata:       (mem_payload.ctrl.wb_sel == WB_PC4) ? mem_payload.pc + word_t'(4)
                                                        : mem_payload.alu_out
    };

    assign wb_fw = '{
        valid:       wb_valid && wb_payload.ctrl.rf_wen,
        can_forward: 1'b1,
        addr:        wb_payload.ctrl.wb_addr,
        wdata:       wb_wdata
    };

    stage_reg #(.payload_t(id_payload_t)) id_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (id_stall),
        .flush       (front_flush),
        .in_valid    (!id_stall),
        .in_payload  (fetch_payload),
        .out_valid   (id_valid),
        .out_payload (id_payload)
    );

    decode_stage decode_stage_inst (
        .id_valid       (id_valid),
        .id_payload     (id_payload),
        .ds_valid_out   (dec_valid),
        .ds_payload_out (dec_payload)
    );

    stage_reg #(.payload_t(ds_payload_t)) ds_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (ds_stall),
        .flush       (front_flush),
        .in_valid    (dec_valid && !id_stall),
        .in_payload  (dec_payload),
        .out_valid   (ds_valid),
        .out_payload (ds_payload)
    );

    operand_select operand_select_inst (
        .ds_valid        (ds_valid),
        .ds_payload      (ds_payload),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .exe_fw          (exe_fw),
        .mem_fw          (mem_fw),
        .wb_fw           (wb_fw),
        .hazard_stall    (hazard_stall),
        .exe_payload_out (sel_payload)
    );

    // the slot behind a taken branch is dropped here
    stage_reg #(.payload_t(exe_payload_t)) exe_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (exe_stall),
        .flush       (branch_redirect),
        .in_valid    (ds_valid && !ds_stall),
        .in_payload  (sel_payload),
        .out_valid   (exe_valid),
        .out_payload (exe_payload)
    );

    execute_stage execute_stage_inst (
        .exe_valid       (exe_valid),
        .exe_payload     (exe_payload),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .mem_payload_out (alu_payload)
    );

    stage_reg #(.payload_t(mem_payload_t)) mem_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (mem_stall),
        .flush       (1'b0),
        .in_valid    (exe_valid && !exe_stall),
        .in_payload  (alu_payload),
        .out_valid   (mem_valid),
        .out_payload (mem_payload)
    );

    memory_stage memory_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .mem_valid      (mem_valid),
        .mem_payload    (mem_payload),
        .dmem_req       (dmem_req),
        .dmem_we        (dmem_we),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_ready     (dmem_ready),
        .dmem_rdata     (dmem_rdata),
        .mem_stall      (mem_stall),
        .wb_payload_out (dmem_payload)
    );

    // wb never stalls, it takes bubbles while mem waits
    stage_reg #(.payload_t(wb_payload_t)) wb_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (1'b0),
        .flush       (1'b0),
        .in_valid    (mem_valid && !mem_stall),
        .in_payload  (dmem_payload),
        .out_valid   (wb_valid),
        .out_payload (wb_payload)
    );

    result_stage result_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_valid   (wb_valid),
        .wb_payload (wb_payload),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .wb_wdata   (wb_wdata),
        .gp         (gp),
        .exit       (exit)
    );

endmodule

`default_nettype wire

/* tests/rv_core_programs.svh */
`ifndef RV_CORE_PROGRAMS_SVH
`define RV_CORE_PROGRAMS_SVH

// back-to-back dependent ALU ops, gp folds several results together
task automatic alu_chain_test();
    logic [31:0] x5;
    logic [31:0] x6;
    logic [31:0] x7;
    logic [31:0] x8;
    logic [31:0] x9;
    logic [31:0] x10;
    logic [31:0] x11;
    logic [31:0] x12;
    logic [31:0] x13;
    logic [31:0] x14;
    logic [31:0] x15;
    logic [31:0] x16;
    logic [31:0] res;
    begin_program();
    emit(enc_u(20'h12345, 5));
    emit(enc_i(12'h678, 5, 3'b000, 5, 7'b0010011));
    emit(enc_i(12'hffd, 0, 3'b000, 6, 7'b0010011));
    emit(enc_r(7'h00, 6, 5, 3'b000, 7));
    emit(enc_r(7'h20, 5, 7, 3'b000, 8));
    emit(enc_r(7'h00, 5, 8, 3'b100, 9));
    emit(enc_r(7'h00, 6, 9, 3'b110, 10));
    emit(enc_r(7'h00, 5, 10, 3'b111, 11));
    emit(enc_i(12'h004, 11, 3'b001, 12, 7'b0010011));
    emit(enc_i(12'h401, 8, 3'b101, 13, 7'b0010011));
    emit(enc_r(7'h00, 6, 9, 3'b101, 14));
    emit(enc_r(7'h00, 5, 8, 3'b010, 15));
    emit(enc_r(7'h00, 5, 8, 3'b011, 16));
    emit(enc_r(7'h00, 13, 12, 3'b000, 3));
    emit(enc_r(7'h00, 14, 3, 3'b100, 3));
    emit(enc_r(7'h00, 15, 3, 3'b000, 3));
    emit(enc_r(7'h20, 16, 3, 3'b000, 3));
    emit(32'h0000_0073);
    release_reset();
    // expected values straight from RV32I semantics
    x5  = 32'h1234_5000 + 32'h678;
    x6  = 32'hffff_fffd;
    x7  = x5 + x6;
    x8  = x7 - x5;
    x9  = x8 ^ x5;
    x10 = x9 | x6;
    x11 = x10 & x5;
    x12 = x11 << 4;
    x13 = $signed(x8) >>> 1;
    x14 = x9 >> x6[4:0];
    x15 = ($signed(x8) < $signed(x5)) ? 32'd1 : 32'd0;
    x16 = (x8 < x5) ? 32'd1 : 32'd0;
    res = (((x12 + x13) ^ x14) + x15) - x16;
    wait_for_exit("alu chain");
    check_value("gp", gp, res);
endtask

// stores, then loads with a dependent add right behind each one
task automatic store_load_test(input logic with_delay);
    logic [31:0] sum;
    begin_program();
    random_delay = with_delay;
    emit(enc_u(20'h00001, 20));
    emit(enc_i(12'h123, 0, 3'b000, 5, 7'b0010011));
    emit(enc_i(12'hfab, 0, 3'b000, 6, 7'b0010011));
    emit(enc_s(12'd0, 5, 20));
    emit(enc_s(12'd8, 6, 20));
    emit(enc_i(12'd0, 20, 3'b010, 7, 7'b0000011));
    emit(enc_r(7'h00, 7, 7, 3'b000, 3));
    emit(enc_i(12'd8, 20, 3'b010, 8, 7'b0000011));
    emit(enc_r(7'h00, 8, 3, 3'b000, 3));
    emit(enc_s(12'd4, 3, 20));
    emit(enc_i(12'd4, 20, 3'b010, 9, 7'b0000011));
    emit(enc_i(12'd1, 9, 3'b000, 3, 7'b0010011));
    emit(32'h0000_0073);
    release_reset();
    sum = 32'h123 + 32'h123 + 32'hffff_ffab;
    wait_for_exit(with_delay ? "store load, random delay" : "store load");
    check_value("gp", gp, sum + 1);
    check_value("write count", wr_addr_q.size(), 3);
    check_value("write 0 addr", wr_addr_q[0], 32'h1000);
    check_value("write 0 data", wr_data_q[0], 32'h123);
    check_value("write 1 addr", wr_addr_q[1], 32'h1008);
    check_value("write 1 data", wr_data_q[1], 32'hffff_ffab);
    check_value("write 2 addr", wr_addr_q[2], 32'h1004);
    check_value("write 2 data", wr_data_q[2], sum);
    random_delay = 1'b0;
endtask

// countdown with bne, then one taken blt, one untaken bge, one taken bge
task automatic branch_loop_test();
    begin_program();
    emit(enc_i(12'd0, 0, 3'b000, 3, 7'b0010011));
    emit(enc_i(12'd7, 0, 3'b000, 5, 7'b0010011));
    emit(enc_i(12'd1, 3, 3'b000, 3, 7'b0010011));
    emit(enc_i(12'hfff, 5, 3'b000, 5, 7'b0010011));
    emit(enc_b(-8, 0, 5, 3'b001));
    emit(enc_i(12'hffe, 0, 3'b000, 6, 7'b0010011));
    emit(enc_b(8, 0, 6, 3'b100));
    emit(enc_i(12'd100, 3, 3'b000, 3, 7'b0010011));
    emit(enc_b(8, 0, 6, 3'b101));
    emit(enc_i(12'd16, 3, 3'b000, 3, 7'b0010011));
    emit(enc_b(8, 6, 0, 3'b101));
    emit(enc_i(12'd100, 3, 3'b000, 3, 7'b0010011));
    emit(32'h0000_0073);
    release_reset();
    wait_for_exit("branch loop");
    check_value("gp", gp, 32'd7 + 32'd16);
endtask

// the two slots behind jal would add 300 if they ever wrote
task automatic jal_skip_test();
    begin_program();
    emit(enc_i(12'd5, 0, 3'b000, 3, 7'b0010011));
    emit(enc_j(12, 1));
    emit(enc_i(12'd100, 3, 3'b000, 3, 7'b0010011));
    emit(enc_i(12'd200, 3, 3'b000, 3, 7'b0010011));
    emit(enc_r(7'h00, 1, 3, 3'b000, 3));
    emit(32'h0000_0073);
    release_reset();
    wait_for_exit("jal skip");
    // link of the jal at pc 4
    check_value("gp", gp, 32'd8 + 32'd5);
endtask

`endif

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam int CLK_PERIOD = 40;
    localparam int TEST_LIMIT = 300;
    localparam int NUM_TESTS  = 5;
    localparam int ROM_WORDS  = 64;
    localparam int RAM_WORDS  = 2048;
    localparam logic [31:0] NOP  = 32'h0000_0013;
    localparam logic [31:0] SEED = 32'hf1bd_f88b;

    logic        clk;
    logic        rst;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_inst;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ready;
    logic [31:0] dmem_rdata;
    logic [31:0] gp;
    logic        exit;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] wr_addr_q[$];
    logic [31:0] wr_data_q[$];
    logic        random_delay;
    int          prog_len;
    int          wait_left;

    rv_core rv_core_inst (
        .clk        (clk),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .fetch_inst (fetch_inst),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .gp         (gp),
        .exit       (exit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // combinational instruction ROM
    assign fetch_inst = rom[fetch_addr[7:2]];

    // data RAM, ready comes wait_left cycles after the request shows up
    initial begin
        void'($urandom(SEED));
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        wait_left  = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                dmem_ready <= 1'b0;
                wait_left  <= 0;
            end else if (dmem_ready) begin
                if (dmem_req && dmem_we) begin
                    ram[dmem_addr[12:2]] <= dmem_wdata;
                    wr_addr_q.push_back(dmem_addr);
                    wr_data_q.push_back(dmem_wdata);
                end
                dmem_ready <= 1'b0;
                wait_left  <= random_delay ? int'($urandom_range(4, 0)) : 0;
            end else if (dmem_req) begin
                if (wait_left == 0) begin
                    dmem_ready <= 1'b1;
                    dmem_rdata <= ram[dmem_addr[12:2]];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

    initial begin
        #((NUM_TESTS * (TEST_LIMIT + 10)) * CLK_PERIOD);
        $display("timeout, the test sequence did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int offset, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        logic [12:0] b;
        b = offset[12:0];
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_j(input int offset, input logic [4:0] rd);
        logic [20:0] j;
        j = offset[20:0];
        return {j[20], j[10:1], j[11], j[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] inst);
        rom[prog_len] = inst;
        prog_len++;
    endtask

    // reset held across the ROM load so nothing half-loaded runs
    task automatic begin_program();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP;
        end
        prog_len = 0;
    endtask

    task automatic release_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wr_addr_q.delete();
        wr_data_q.delete();
        @(negedge clk);
        check_value("exit", {31'b0, exit}, 32'h0);
    endtask

    task automatic wait_for_exit(input string test_name);
        int n;
        n = 0;
        while (!exit && n < TEST_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!exit) begin
            $display("%s: program did not reach ecall within %0d cycles", test_name, n);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

`include "rv_core_programs.svh"

    initial begin
        rst          = 1'b1;
        random_delay = 1'b0;
        prog_len     = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP;
        end
        // fill pattern uses every address bit
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = (i * 32'h0101_0101) ^ 32'ha5c3_0f96 ^ (i << 20);
        end
        alu_chain_test();
        store_load_test(1'b0);
        branch_loop_test();
        jal_skip_test();
        store_load_test(1'b1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_pipe.f */
+incdir+verilog
+incdir+tests
verilog/rv_pipe_pkg.sv
verilog/stage_reg.sv
verilog/decode_stage.sv
verilog/operand_select.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/result_stage.sv
verilog/rv_core.sv
tests/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_pipe

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pipe_pkg.sv
      - verilog/stage_reg.sv
      - verilog/decode_stage.sv
      - verilog/operand_select.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/result_stage.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/rv_core_tb.sv
